// ==== Bender.yml ====
package:
  name: draw_controller

export_include_dirs:
  - .

sources:
  - draw_pkg.sv
  - draw_frame_sequencer.sv
  - sprite_addr_gen.sv
  - sprite_fetch.sv
  - draw_controller.sv
  - target: test
    files:
      - draw_controller_asserts.sv
      - tb_draw_controller.sv

// ==== draw_config.svh ====
/* fixed screen layout, sprite base addresses and memory read latency
   of the draw controller, included by every block that needs them */

`ifndef DRAW_CONFIG_SVH
`define DRAW_CONFIG_SVH

// lanes of the play field
`define DRAW_ROWS 4
`define ROW_TOP 200
`define ROW_HEIGHT 60
`define BUTTON_X 420 // key indicators start here

// button sprites, 60x60 each, stored column by column
`define ADDR_DOWN_BUTTON 19080
`define ADDR_UP_BUTTON 22680

// judgment signs
`define ADDR_PERFECT 4800
`define ADDR_GREAT 6336
`define ADDR_GOOD 7872
`define ADDR_BAD 9408
`define ADDR_MISS 10944
`define SIGN_W 24
`define SIGN_H 64
`define SIGN_Y 453
`define SIGN_X_PERFECT 396
`define SIGN_X_GREAT 356
`define SIGN_X_GOOD 316
`define SIGN_X_BAD 276
`define SIGN_X_MISS 236

// registered address to color capture
`define SPRITE_RD_LATENCY 3

`endif

// ==== draw_controller.f ====
+incdir+.
draw_pkg.sv
draw_frame_sequencer.sv
sprite_addr_gen.sv
sprite_fetch.sv
draw_controller.sv
draw_controller_asserts.sv
tb_draw_controller.sv

// ==== draw_controller.sv ====
/* top of the per-frame draw controller
   frame sequencer, sprite address generator and sprite fetch */

`timescale 1ns/1ps
`default_nettype none

module draw_controller (
	input wire CLK,
	input wire RESET_L,
	input wire sig_on,
	input wire draw_pkg::play_pos_t current_pixel,
	input wire draw_pkg::row_mask_t key_down,
	output logic sig_done,
	output logic vga_reset,
	output draw_pkg::row_mask_t refresh_on,
	output logic buffer_sel,
	output draw_pkg::play_pos_t refresh_pixel,
	output draw_pkg::row_mask_t next_line,
	input wire draw_pkg::row_mask_t refresh_done,
	input wire draw_pkg::vga_req_t vga,
	output draw_pkg::rgb_t color,
	output draw_pkg::sprite_addr_t ds_addr,
	output logic ds_en,
	input wire draw_pkg::sprite_word_t ds_data
);

	logic first_frame;
	logic issue;
	logic blank;

	draw_frame_sequencer i_sequencer (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.sig_on(sig_on),
		.current_pixel(current_pixel),
		.refresh_done(refresh_done),
		.sig_done(sig_done),
		.vga_reset(vga_reset),
		.first_frame(first_frame),
		.buffer_sel(buffer_sel),
		.refresh_on(refresh_on),
		.refresh_pixel(refresh_pixel)
	);

	sprite_addr_gen i_addr_gen (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.vga(vga),
		.key_down(key_down),
		.first_frame(first_frame),
		.ds_addr(ds_addr),
		.issue(issue),
		.blank(blank),
		.next_line(next_line)
	);

	sprite_fetch i_fetch (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.issue(issue),
		.blank(blank),
		.ds_data(ds_data),
		.ds_en(ds_en),
		.color(color)
	);

endmodule

`default_nettype wire

// ==== draw_controller_asserts.sv ====
/* timing checks on the draw controller top level
   bound into it by the testbench, failures counted in fail_count */

`timescale 1ns/1ps
`default_nettype none

module draw_controller_asserts (
	input wire CLK,
	input wire RESET_L,
	input wire draw_pkg::row_mask_t refresh_on,
	input wire sig_done,
	input wire first_frame,
	input wire ds_en
);

	int fail_count = 0;

	// at most one lane refreshing
	onehot_refresh: assert property (@(posedge CLK) disable iff (!RESET_L) $onehot0(refresh_on))
		else begin
			fail_count++;
			$error("refresh_on strobes more than one lane");
		end

	done_pulse: assert property (@(posedge CLK) disable iff (!RESET_L) sig_done |=> !sig_done)
		else begin
			fail_count++;
			$error("sig_done held longer than one cycle");
		end

	no_read_first: assert property (@(posedge CLK) disable iff (!RESET_L) first_frame |-> !ds_en)
		else begin
			fail_count++;
			$error("sprite read during the first frame");
		end

endmodule

`default_nettype wire

// ==== draw_frame_sequencer.sv ====
/* per-frame bookkeeping and lane refresh sequencing
   each start strobe flips the ping-pong buffer and refreshes lanes 0 to 3 in turn */

`timescale 1ns/1ps
`default_nettype none

`include "draw_config.svh"

module draw_frame_sequencer (
	input wire CLK,
	input wire RESET_L,
	input wire sig_on,
	input wire draw_pkg::play_pos_t current_pixel,
	input wire draw_pkg::row_mask_t refresh_done,
	output logic sig_done,
	output logic vga_reset,
	output logic first_frame,
	output logic buffer_sel,
	output draw_pkg::row_mask_t refresh_on,
	output draw_pkg::play_pos_t refresh_pixel
);

	import draw_pkg::*;

	seq_state_t state, state_next;
	logic [1:0] row; // lane being refreshed
	logic working;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			working <= 1'b0;
			first_frame <= 1'b1;
			buffer_sel <= 1'b0;
			state <= s_idle;
			row <= '0;
		end else begin
			if (sig_on) begin
				working <= 1'b1;
				buffer_sel <= !buffer_sel;
				if (working)
					first_frame <= 1'b0; // second start, display buffer now valid
			end
			state <= state_next;
			if (state == s_idle)
				row <= '0;
			else if (state == s_refresh_wait && refresh_done[row])
				row <= row + 1'b1;
		end
	end

	// position the column controllers work from
	always_ff @(posedge CLK) begin
		if (sig_on)
			refresh_pixel <= current_pixel;
	end

	always_comb begin
		state_next = state;
		case (state)
			s_idle: begin
				if (sig_on)
					state_next = s_refresh_strobe;
			end
			s_refresh_strobe:
				state_next = s_refresh_wait;
			s_refresh_wait: begin
				if (refresh_done[row])
					state_next = (row == 2'(`DRAW_ROWS - 1)) ? s_done : s_refresh_strobe;
			end
			s_done:
				state_next = s_idle;
			default:
				state_next = s_idle;
		endcase
	end

	assign refresh_on = (state == s_refresh_strobe) ? row_mask_t'(1) << row : '0;
	assign sig_done = state == s_done;
	assign vga_reset = !working;

endmodule

`default_nettype wire

// ==== draw_pkg.sv ====
/* types shared by the draw controller blocks
   and its testbench */

`default_nettype none

package draw_pkg;

	typedef logic [9:0] coord_t; // vga column or line
	typedef logic [14:0] sprite_addr_t;
	typedef logic [15:0] sprite_word_t;
	typedef logic [3:0] nibble_t;
	typedef logic [3:0] row_mask_t; // one bit per lane
	typedef logic [31:0] play_pos_t;

	// pixel request from the vga scanner
	typedef struct packed {
		logic req;
		coord_t x;
		coord_t y;
	} vga_req_t;

	typedef struct packed {
		nibble_t r;
		nibble_t g;
		nibble_t b;
	} rgb_t;

	typedef enum logic [1:0] {
		s_idle,
		s_refresh_strobe,
		s_refresh_wait,
		s_done
	} seq_state_t;

endpackage

`default_nettype wire

// ==== sprite_addr_gen.sv ====
/* turns each vga pixel request into a registered sprite memory address
   plus issue or blank pulse, and flags the last line of each lane */

`timescale 1ns/1ps
`default_nettype none

`include "draw_config.svh"

module sprite_addr_gen (
	input wire CLK,
	input wire RESET_L,
	input wire draw_pkg::vga_req_t vga,
	input wire draw_pkg::row_mask_t key_down,
	input wire first_frame,
	output draw_pkg::sprite_addr_t ds_addr,
	output logic issue,
	output logic blank,
	output draw_pkg::row_mask_t next_line
);

	import draw_pkg::*;

	localparam int n_signs = 5;

	// perfect, great, good, bad, miss
	localparam sprite_addr_t sign_base [n_signs] = '{
		`ADDR_PERFECT, `ADDR_GREAT, `ADDR_GOOD, `ADDR_BAD, `ADDR_MISS
	};
	localparam coord_t sign_left [n_signs] = '{
		`SIGN_X_PERFECT, `SIGN_X_GREAT, `SIGN_X_GOOD, `SIGN_X_BAD, `SIGN_X_MISS
	};

	sprite_addr_t addr_next;

	always_comb begin
		int top;
		addr_next = '0; // note area and background
		for (int r = 0; r < `DRAW_ROWS; r++) begin
			top = `ROW_TOP + r * `ROW_HEIGHT;
			if (vga.y >= top && vga.y < top + `ROW_HEIGHT && vga.x >= `BUTTON_X) begin
				// key indicator, sprite stored column by column
				addr_next = sprite_addr_t'((key_down[r] ? `ADDR_DOWN_BUTTON : `ADDR_UP_BUTTON)
					+ (vga.x - `BUTTON_X) * `ROW_HEIGHT + (vga.y - top));
			end
		end
		for (int s = 0; s < n_signs; s++) begin
			if (vga.x >= sign_left[s] && vga.x < sign_left[s] + `SIGN_W &&
					vga.y >= `SIGN_Y && vga.y < `SIGN_Y + `SIGN_H) begin
				addr_next = sprite_addr_t'(sign_base[s]
					+ (vga.x - sign_left[s]) * `SIGN_H + (vga.y - `SIGN_Y));
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			issue <= 1'b0;
			blank <= 1'b0;
		end else begin
			issue <= vga.req && !first_frame;
			blank <= vga.req && first_frame; // nothing drawn yet, show black
		end
	end

	always_ff @(posedge CLK) begin
		if (vga.req)
			ds_addr <= addr_next;
	end

	// bottom edge of each lane
	always_comb begin
		for (int r = 0; r < `DRAW_ROWS; r++)
			next_line[r] = vga.req && vga.y == `ROW_TOP + (r + 1) * `ROW_HEIGHT;
	end

endmodule

`default_nettype wire

// ==== sprite_fetch.sv ====
/* sprite memory read side
   reads stay in flight for a fixed latency, then the color is registered */

`timescale 1ns/1ps
`default_nettype none

`include "draw_config.svh"

module sprite_fetch (
	input wire CLK,
	input wire RESET_L,
	input wire issue,
	input wire blank,
	input wire draw_pkg::sprite_word_t ds_data,
	output logic ds_en,
	output draw_pkg::rgb_t color
);

	localparam int lat = `SPRITE_RD_LATENCY;

	logic [lat-1:0] issue_dly; // reads in flight
	logic [lat-1:0] blank_dly;

	assign ds_en = issue;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			issue_dly <= '0;
			blank_dly <= '0;
			color <= '0;
		end else begin
			issue_dly <= {issue_dly[lat-2:0], issue};
			blank_dly <= {blank_dly[lat-2:0], blank};
			if (issue_dly[lat-1]) begin
				color.r <= ds_data[3:0];
				color.g <= ds_data[7:4];
				color.b <= ds_data[11:8];
			end else if (blank_dly[lat-1]) begin
				color <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_draw_controller.sv ====
/* testbench of the draw controller, run from the project root with the file list
   frames with random refresh delays, pixel tables checked against a sprite memory model */

`timescale 1ns/1ps
`default_nettype none

`include "draw_config.svh"

module tb_draw_controller;

	import draw_pkg::*;

	typedef struct packed {
		coord_t x;
		coord_t y;
		row_mask_t keys;
		sprite_addr_t addr; // base + column * height + line, modulo 2^15
	} pix_entry_t;

	localparam int period = 4;
	localparam int n_pix = 17;
	localparam int n_key = 8; // key indicator entries come first
	localparam int n_nl = 8;
	localparam int gap = 5;
	// each entry finishes well inside 16 cycles, frames count four entries
	localparam int wd_limit = (2 * 2 * n_pix + n_nl + 4 * 4) * 16 * period + 200;

	localparam pix_entry_t pix_tab [n_pix] = '{
		{10'd420, 10'd200, 4'b0001, 15'd19080}, {10'd425, 10'd210, 4'b0000, 15'd22990},
		{10'd430, 10'd265, 4'b0010, 15'd19685}, {10'd479, 10'd319, 4'b0000, 15'd26279},
		{10'd421, 10'd379, 4'b0011, 15'd22799}, {10'd450, 10'd400, 4'b1000, 15'd20900},
		{10'd600, 10'd439, 4'b1000, 15'd29939}, {10'd700, 10'd420, 4'b0000, 15'd6752},
		{10'd419, 10'd516, 4'b0000, 15'd6335}, {10'd360, 10'd460, 4'b0000, 15'd6599},
		{10'd330, 10'd500, 4'b0000, 15'd8815}, {10'd276, 10'd470, 4'b0000, 15'd9425},
		{10'd250, 10'd480, 4'b0000, 15'd11867}, {10'd100, 10'd230, 4'b0000, 15'd0},
		{10'd500, 10'd100, 4'b0000, 15'd0}, {10'd300, 10'd470, 4'b0000, 15'd0},
		{10'd420, 10'd440, 4'b0000, 15'd0}
	};
	localparam coord_t nl_y [n_nl] = '{260, 320, 380, 440, 200, 259, 261, 500};
	localparam row_mask_t nl_mask [n_nl] = '{1, 2, 4, 8, 0, 0, 0, 0};

	logic CLK, RESET_L, sig_on, sig_done, vga_reset, buffer_sel, ds_en;
	play_pos_t current_pixel, refresh_pixel;
	row_mask_t key_down, refresh_on, refresh_done, next_line;
	vga_req_t vga;
	rgb_t color;
	sprite_addr_t ds_addr;
	sprite_addr_t addr_q = '0;
	sprite_addr_t addr_qq = '0;
	sprite_word_t ds_data = '0;
	logic [31:0] lfsr = 32'h9cc6_f71f;
	logic no_en = 1'b0;
	logic exp_buf = 1'b0;
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	int mark = 0;
	int due_q [$];
	rgb_t exp_q [$];

	draw_controller i_draw_controller (.*);

	bind draw_controller draw_controller_asserts i_asserts (.CLK(CLK), .RESET_L(RESET_L),
		.refresh_on(refresh_on), .sig_done(sig_done), .first_frame(first_frame), .ds_en(ds_en));

	initial begin
		CLK = 1'b0;
		forever #(period / 2) CLK = ~CLK;
	end

	// sprite memory, word holds its own address
	always @(posedge CLK) begin
		cyc <= cyc + 1;
		if (ds_en)
			addr_q <= ds_addr;
		addr_qq <= addr_q;
		ds_data <= {1'b0, addr_qq};
	end

	task automatic check(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("** Error @ %0t ns: %s", $time, what);
		end
	endtask

	task automatic report(input string name);
		$display("%s: %0d errors", name, errors - mark);
		mark = errors;
	endtask

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	// memory word equals the address, so r g b are address nibbles 0 1 2
	function automatic rgb_t color_of(input sprite_addr_t a);
		return {a[3:0], a[7:4], a[11:8]};
	endfunction

	always @(negedge CLK) begin
		if (no_en)
			check(!ds_en, "ds_en high during the first frame");
		if (due_q.size() > 0 && cyc == due_q[0]) begin
			check(color == exp_q[0], $sformatf("color %h, expected %h", color, exp_q[0]));
			void'(due_q.pop_front());
			void'(exp_q.pop_front());
		end
	end

	task automatic run_pixels(input int first, input int count, input int idle, input logic black);
		for (int k = first; k < first + count; k++) begin
			vga = {1'b1, pix_tab[k].x, pix_tab[k].y};
			key_down = pix_tab[k].keys;
			due_q.push_back(cyc + 5); // sampled at the next edge, color 4 edges later
			exp_q.push_back(black ? rgb_t'(0) : color_of(pix_tab[k].addr));
			@(posedge CLK);
			#1 vga.req = 1'b0;
			check(ds_addr == pix_tab[k].addr && ds_en == !black,
				$sformatf("ds_addr %0d ds_en %b, expected %0d", ds_addr, ds_en,
				pix_tab[k].addr));
			repeat (idle) begin
				@(posedge CLK);
				#1;
			end
		end
		wait (due_q.size() == 0);
		@(posedge CLK);
		#1;
	endtask

	task automatic run_frame(input play_pos_t pos);
		int d;
		sig_on = 1'b1;
		current_pixel = pos;
		@(posedge CLK);
		#1 sig_on = 1'b0;
		current_pixel = ~pos; // latch holds the value seen with the strobe
		exp_buf = !exp_buf;
		for (int r = 0; r < `DRAW_ROWS; r++) begin
			@(negedge CLK);
			check(refresh_on == row_mask_t'(1 << r),
				$sformatf("refresh_on %b at lane %0d", refresh_on, r));
			d = rand_bits(3);
			@(posedge CLK);
			repeat (d) begin
				#1 check(refresh_on == '0, "refresh_on outside its strobe cycle");
				@(posedge CLK);
			end
			#1 refresh_done[r] = 1'b1;
			@(posedge CLK);
			#1 refresh_done[r] = 1'b0;
		end
		@(negedge CLK);
		check(sig_done && refresh_on == '0, "sig_done missing after lane 3");
		check(!vga_reset && buffer_sel == exp_buf && refresh_pixel == pos,
			"frame flags or position");
		@(negedge CLK);
		check(!sig_done, "sig_done longer than one cycle");
		@(posedge CLK);
		#1;
	endtask

	initial begin
		RESET_L = 1'b0;
		sig_on = 1'b0;
		current_pixel = '0;
		key_down = '0;
		refresh_done = '0;
		vga = '0;
		repeat (5) @(posedge CLK);
		#1 RESET_L = 1'b1;
		@(negedge CLK);
		check(vga_reset && !sig_done && refresh_on == '0 && !ds_en && color == '0,
			"state after reset");
		report("reset");
		@(posedge CLK);
		#1 no_en = 1'b1;
		run_frame(32'h0000_1234);
		run_pixels(0, n_key, 0, 1'b1); // nothing drawn yet
		no_en = 1'b0;
		report("first frame");
		for (int f = 0; f < 3; f++)
			run_frame(play_pos_t'(rand_bits(32)));
		report("frame sequence");
		run_pixels(0, n_key, 0, 1'b0);
		run_pixels(0, n_key, gap, 1'b0);
		report("key indicators");
		run_pixels(n_key, n_pix - n_key, 0, 1'b0);
		run_pixels(n_key, n_pix - n_key, gap, 1'b0);
		report("signs and blank areas");
		for (int i = 0; i < n_nl; i++) begin
			vga = {1'b1, coord_t'(430), nl_y[i]};
			@(negedge CLK);
			check(next_line == nl_mask[i],
				$sformatf("next_line %b at line %0d", next_line, nl_y[i]));
			@(posedge CLK);
			#1;
		end
		vga.req = 1'b0;
		report("next line");
		errors += i_draw_controller.i_asserts.fail_count;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		#(wd_limit);
		$display("timeout, the run did not finish within %0d ns", wd_limit);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
